// File: Makefile
TOP := backend_core_tb

all: run

build:
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "SIMULATION FAILED" >> sim.log
	cat sim.log
	! grep -q "SIMULATION FAILED" sim.log

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: build.f
+incdir+logic
logic/backend_pkg.sv
logic/backend_ifs.sv
logic/dispatch_stage.sv
logic/exec_stage.sv
logic/reorder_buffer.sv
logic/register_file.sv
logic/backend_core.sv
test/backend_core_tb.sv

// File: logic/backend_core.sv
`timescale 1ns/10ps
`default_nettype none

module backend_core import backend_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     rdy_in,
    input  logic     clr_in,
    input  logic     instr_valid,
    input  reg_idx_t instr_rd,
    input  reg_idx_t instr_rs1,
    input  reg_idx_t instr_rs2,
    input  op_t      instr_op,
    input  logic     instr_use_imm,
    input  data_t    instr_imm,
    output logic     instr_ready,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output data_t    commit_value
);

    regread_if   rd_bus ();
    rob_alloc_if alloc_bus ();
    exec_if      exec_bus ();
    commit_if    commit_bus ();

    logic     wb_valid;
    rob_tag_t wb_tag;
    data_t    wb_value;

    dispatch_stage u_dispatch (
        .clk_in, .rst_in, .rdy_in, .clr_in,
        .instr_valid, .instr_use_imm, .instr_rd, .instr_rs1, .instr_rs2,
        .instr_op, .instr_imm, .instr_ready,
        .rd_port    (rd_bus),
        .alloc_port (alloc_bus),
        .issue      (exec_bus)
    );

    exec_stage u_exec (
        .clk_in, .rst_in, .rdy_in, .clr_in,
        .issue (exec_bus),
        .wb_valid, .wb_tag, .wb_value
    );

    reorder_buffer u_rob (
        .clk_in, .rst_in, .rdy_in, .clr_in,
        .alloc_port  (alloc_bus),
        .wb_valid, .wb_tag, .wb_value,
        .commit_port (commit_bus)
    );

    register_file u_regfile (
        .clk_in, .rst_in, .rdy_in, .clr_in,
        .issue_valid (alloc_bus.alloc),
        .issue_rd    (alloc_bus.alloc_rd),
        .issue_tag   (alloc_bus.free_tag),
        .rd_port     (rd_bus),
        .commit_port (commit_bus)
    );

    // A commit held through a freeze shows once rdy_in returns.
    assign commit_valid = commit_bus.commit && rdy_in && !clr_in;
    assign commit_rd    = commit_bus.rd;
    assign commit_value = commit_bus.value;

endmodule

`default_nettype wire

// File: logic/backend_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// Source lookups from dispatch into the register file.
interface regread_if import backend_pkg::*; ();
    reg_idx_t rs1;
    reg_idx_t rs2;
    data_t    val1;
    data_t    val2;
    rob_tag_t dep1;
    rob_tag_t dep2;

    modport dispatch (output rs1, rs2, input val1, val2, dep1, dep2);
    modport regfile  (input rs1, rs2, output val1, val2, dep1, dep2);
endinterface

interface rob_alloc_if import backend_pkg::*; ();
    rob_tag_t free_tag;
    logic     full;
    logic     alloc;
    reg_idx_t alloc_rd;
    rob_tag_t query_tag1;
    rob_tag_t query_tag2;
    logic     ready1;
    logic     ready2;
    data_t    qval1;
    data_t    qval2;

    modport dispatch (input free_tag, full, ready1, ready2, qval1, qval2,
                      output alloc, alloc_rd, query_tag1, query_tag2);
    modport rob      (output free_tag, full, ready1, ready2, qval1, qval2,
                      input alloc, alloc_rd, query_tag1, query_tag2);
endinterface

interface exec_if import backend_pkg::*; ();
    logic     valid;
    rob_tag_t tag;
    op_t      op;
    data_t    opa;
    data_t    opb;

    modport source (output valid, tag, op, opa, opb);
    modport sink   (input valid, tag, op, opa, opb);
endinterface

interface commit_if import backend_pkg::*; ();
    logic     commit;  // One cycle per retired entry.
    rob_tag_t tag;
    reg_idx_t rd;
    data_t    value;

    modport source (output commit, tag, rd, value);
    modport sink   (input commit, tag, rd, value);
endinterface

`default_nettype wire

// File: logic/backend_macros.svh
`ifndef BACKEND_MACROS_SVH
`define BACKEND_MACROS_SVH

`define REG_COUNT     32
`define DATA_WIDTH    32

// Tag 0 stays reserved for "no dependency".
`define ROB_DEPTH     8
`define ROB_TAG_WIDTH 3

`endif

// File: logic/backend_pkg.sv
`default_nettype none

`include "backend_macros.svh"

package backend_pkg;

    typedef logic [`DATA_WIDTH-1:0]        data_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
    typedef logic [`ROB_TAG_WIDTH-1:0]     rob_tag_t;  // Zero means not waiting.
    typedef logic [1:0]                    op_t;

    localparam op_t OP_ADD = 2'd0;
    localparam op_t OP_SUB = 2'd1;
    localparam op_t OP_AND = 2'd2;
    localparam op_t OP_XOR = 2'd3;

endpackage

`default_nettype wire

// File: logic/dispatch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_stage import backend_pkg::*; (
    input  logic          clk_in,
    input  logic          rst_in,
    input  logic          rdy_in,
    input  logic          clr_in,
    input  logic          instr_valid,
    input  logic          instr_use_imm,
    input  reg_idx_t      instr_rd,
    input  reg_idx_t      instr_rs1,
    input  reg_idx_t      instr_rs2,
    input  op_t           instr_op,
    input  data_t         instr_imm,
    output logic          instr_ready,
    regread_if.dispatch   rd_port,
    rob_alloc_if.dispatch alloc_port,
    exec_if.source        issue
);

    logic  avail1;
    logic  avail2;
    logic  accept;
    data_t opa;
    data_t opb;

    assign rd_port.rs1 = instr_rs1;
    assign rd_port.rs2 = instr_rs2;

    // Pending tags go to the buffer for forwarding.
    assign alloc_port.query_tag1 = rd_port.dep1;
    assign alloc_port.query_tag2 = rd_port.dep2;

    // A waiting source may still go once its producer has written back.
    assign avail1 = (rd_port.dep1 == '0) || alloc_port.ready1;
    assign avail2 = instr_use_imm || (rd_port.dep2 == '0) || alloc_port.ready2;

    assign opa = (rd_port.dep1 == '0) ? rd_port.val1 : alloc_port.qval1;
    assign opb = instr_use_imm          ? instr_imm :
                 (rd_port.dep2 == '0)   ? rd_port.val2 : alloc_port.qval2;

    assign instr_ready = rdy_in && !alloc_port.full && avail1 && avail2;
    assign accept      = instr_valid && instr_ready && !clr_in;

    assign alloc_port.alloc    = accept;
    assign alloc_port.alloc_rd = instr_rd;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            issue.valid <= 1'b0;
        end else if (rdy_in) begin
            issue.valid <= accept;  // Also drops on flush.
            if (accept) begin
                issue.tag <= alloc_port.free_tag;
                issue.op  <= instr_op;
                issue.opa <= opa;
                issue.opb <= opb;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stage import backend_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     rdy_in,
    input  logic     clr_in,
    exec_if.sink     issue,
    output logic     wb_valid,
    output rob_tag_t wb_tag,
    output data_t    wb_value
);

    data_t result;

    always_comb begin
        case (issue.op)
            OP_ADD: result = issue.opa + issue.opb;
            OP_SUB: result = issue.opa - issue.opb;
            OP_AND: result = issue.opa & issue.opb;
            OP_XOR: result = issue.opa ^ issue.opb;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wb_valid <= 1'b0;
        end else if (rdy_in) begin
            wb_valid <= issue.valid && !clr_in;
            wb_tag   <= issue.tag;
            wb_value <= result;
        end
    end

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_macros.svh"

module register_file import backend_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       rdy_in,
    input  logic       clr_in,
    input  logic       issue_valid,
    input  reg_idx_t   issue_rd,
    input  rob_tag_t   issue_tag,
    regread_if.regfile rd_port,
    commit_if.sink     commit_port
);

    data_t    reg_value [`REG_COUNT];
    rob_tag_t reg_tag   [`REG_COUNT];  // Youngest writer in flight.
    logic     hit1;
    logic     hit2;

    // Commit tags are never zero, so register 0 never hits.
    assign hit1 = commit_port.commit && (commit_port.tag == reg_tag[rd_port.rs1]);
    assign hit2 = commit_port.commit && (commit_port.tag == reg_tag[rd_port.rs2]);

    assign rd_port.val1 = hit1 ? commit_port.value : reg_value[rd_port.rs1];
    assign rd_port.dep1 = hit1 ? '0 : reg_tag[rd_port.rs1];
    assign rd_port.val2 = hit2 ? commit_port.value : reg_value[rd_port.rs2];
    assign rd_port.dep2 = hit2 ? '0 : reg_tag[rd_port.rs2];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                reg_value[i] <= '0;
                reg_tag[i]   <= '0;
            end
        end else if (rdy_in) begin
            if (clr_in) begin
                for (int i = 0; i < `REG_COUNT; i++) begin
                    reg_tag[i] <= '0;
                end
            end else begin
                if (commit_port.commit && commit_port.rd != '0) begin
                    reg_value[commit_port.rd] <= commit_port.value;
                    if (reg_tag[commit_port.rd] == commit_port.tag) begin
                        reg_tag[commit_port.rd] <= '0;
                    end
                end
                // Later assignment, so a same-cycle issue keeps its tag.
                if (issue_valid && issue_rd != '0) begin
                    reg_tag[issue_rd] <= issue_tag;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_macros.svh"

module reorder_buffer import backend_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     rdy_in,
    input  logic     clr_in,
    rob_alloc_if.rob alloc_port,
    input  logic     wb_valid,
    input  rob_tag_t wb_tag,
    input  data_t    wb_value,
    commit_if.source commit_port
);

    localparam rob_tag_t LAST_TAG = rob_tag_t'(`ROB_DEPTH - 1);

    // Slot 0 is never allocated.
    reg_idx_t ent_rd    [`ROB_DEPTH];
    data_t    ent_value [`ROB_DEPTH];
    logic     ent_ready [`ROB_DEPTH];

    rob_tag_t                  head;
    rob_tag_t                  tail;
    logic [`ROB_TAG_WIDTH-1:0] count;
    logic                      do_commit;

    function automatic rob_tag_t next_tag(input rob_tag_t t);
        return (t == LAST_TAG) ? rob_tag_t'(1) : t + rob_tag_t'(1);
    endfunction

    assign alloc_port.free_tag = tail;
    assign alloc_port.full     = (count == LAST_TAG);

    // Operand lookups for dispatch.
    assign alloc_port.ready1 = ent_ready[alloc_port.query_tag1];
    assign alloc_port.ready2 = ent_ready[alloc_port.query_tag2];
    assign alloc_port.qval1  = ent_value[alloc_port.query_tag1];
    assign alloc_port.qval2  = ent_value[alloc_port.query_tag2];

    assign do_commit = (count != '0) && ent_ready[head];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head               <= rob_tag_t'(1);
            tail               <= rob_tag_t'(1);
            count              <= '0;
            commit_port.commit <= 1'b0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                ent_ready[i] <= 1'b0;
            end
        end else if (rdy_in) begin
            if (clr_in) begin
                head               <= rob_tag_t'(1);
                tail               <= rob_tag_t'(1);
                count              <= '0;
                commit_port.commit <= 1'b0;  // Pending commit is dropped.
            end else begin
                commit_port.commit <= do_commit;
                if (do_commit) begin
                    commit_port.tag   <= head;
                    commit_port.rd    <= ent_rd[head];
                    commit_port.value <= ent_value[head];
                    head              <= next_tag(head);
                end
                if (alloc_port.alloc) begin
                    ent_rd[tail]    <= alloc_port.alloc_rd;
                    ent_ready[tail] <= 1'b0;
                    tail            <= next_tag(tail);
                end
                if (wb_valid) begin
                    ent_value[wb_tag] <= wb_value;
                    ent_ready[wb_tag] <= 1'b1;
                end
                if (alloc_port.alloc && !do_commit) begin
                    count <= count + 1'b1;
                end else if (!alloc_port.alloc && do_commit) begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/backend_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_macros.svh"

module backend_core_tb import backend_pkg::*; ();

    localparam int WAIT_LIMIT = 100;
    localparam int DRAIN_LIMIT = 200;

    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        op_t      op;
        logic     use_imm;
        data_t    imm;
    } instr_t;

    typedef logic [`REG_COUNT-1:0][`DATA_WIDTH-1:0] regs_t;

    logic     clk_in;
    logic     rst_in;
    logic     rdy_in;
    logic     clr_in;
    logic     instr_valid;
    reg_idx_t instr_rd;
    reg_idx_t instr_rs1;
    reg_idx_t instr_rs2;
    op_t      instr_op;
    logic     instr_use_imm;
    data_t    instr_imm;
    logic     instr_ready;
    logic     commit_valid;
    reg_idx_t commit_rd;
    data_t    commit_value;

    instr_t      pending [$];  // Accepted, not yet committed.
    regs_t       model;
    logic [31:0] lfsr;
    int          errors;
    int          commits;
    int          accepted;
    int          dropped;

    backend_core dut (
        .clk_in, .rst_in, .rdy_in, .clr_in,
        .instr_valid, .instr_rd, .instr_rs1, .instr_rs2, .instr_op,
        .instr_use_imm, .instr_imm, .instr_ready,
        .commit_valid, .commit_rd, .commit_value
    );

    always #10 clk_in = ~clk_in;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic instr_t make_instr(input reg_idx_t rd, input reg_idx_t rs1,
                                          input reg_idx_t rs2, input op_t op,
                                          input logic use_imm, input data_t imm);
        instr_t ins;
        ins.rd      = rd;
        ins.rs1     = rs1;
        ins.rs2     = rs2;
        ins.op      = op;
        ins.use_imm = use_imm;
        ins.imm     = imm;
        return ins;
    endfunction

    // Registers 0 to 7 only, so dependencies are frequent.
    function automatic instr_t rand_instr();
        instr_t ins;
        ins.rd      = reg_idx_t'(take_bits(3));
        ins.rs1     = reg_idx_t'(take_bits(3));
        ins.rs2     = reg_idx_t'(take_bits(3));
        ins.op      = op_t'(take_bits(2));
        ins.use_imm = take_bits(1) == 32'd1;
        ins.imm     = take_bits(32);
        return ins;
    endfunction

    // In-order result of one instruction against the committed registers.
    function automatic data_t ref_result(input regs_t regs, input instr_t ins);
        data_t a;
        data_t b;
        data_t res;
        a = (ins.rs1 == '0) ? '0 : regs[ins.rs1];
        b = ins.use_imm ? ins.imm : ((ins.rs2 == '0) ? '0 : regs[ins.rs2]);
        res = '0;
        case (ins.op)
            OP_ADD: res = a + b;
            OP_SUB: res = a - b;
            OP_AND: res = a & b;
            OP_XOR: res = a ^ b;
        endcase
        return res;
    endfunction

    task automatic check_value(input string name, input data_t got, input data_t want);
        if (got !== want) begin
            $display("** Error: %s is %h, expected %h at %0t", name, got, want, $time);
            errors++;
        end
    endtask

    always @(posedge clk_in) begin : monitor
        instr_t ins;
        data_t  want;
        if (!rst_in) begin
            if (!rdy_in) begin
                check_value("commit_valid", data_t'(commit_valid), '0);
                check_value("instr_ready", data_t'(instr_ready), '0);
            end
            if (commit_valid) begin
                if (pending.size() == 0) begin
                    $display("Commit of register %0d arrived with nothing pending", commit_rd);
                    errors++;
                end else begin
                    ins  = pending.pop_front();
                    want = ref_result(model, ins);
                    check_value("commit_rd", data_t'(commit_rd), data_t'(ins.rd));
                    check_value("commit_value", commit_value, want);
                    if (ins.rd != '0) model[ins.rd] = want;  // Register 0 stays zero.
                    commits++;
                end
            end
            if (clr_in && rdy_in) begin
                dropped = pending.size();
                pending.delete();
            end
            if (instr_valid && instr_ready && rdy_in && !clr_in) begin
                pending.push_back(make_instr(instr_rd, instr_rs1, instr_rs2, instr_op,
                                             instr_use_imm, instr_imm));
                accepted++;
            end
        end
    end

    // Called on a falling edge, returns on the falling edge after acceptance.
    task automatic send_instr(input instr_t ins);
        int   waited;
        logic taken;
        waited        = 0;
        taken         = 1'b0;
        instr_valid   = 1'b1;
        instr_rd      = ins.rd;
        instr_rs1     = ins.rs1;
        instr_rs2     = ins.rs2;
        instr_op      = ins.op;
        instr_use_imm = ins.use_imm;
        instr_imm     = ins.imm;
        while (!taken && waited < WAIT_LIMIT) begin
            @(posedge clk_in);
            taken = instr_ready && rdy_in && !clr_in;
            waited++;
            @(negedge clk_in);
        end
        instr_valid = 1'b0;
        if (!taken) begin
            $display("Timeout: instruction for r%0d not accepted in %0d cycles",
                     ins.rd, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            send_instr(rand_instr());
            repeat (take_bits(2)) @(negedge clk_in);  // Idle gap of 0 to 3 cycles.
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk_in);
            waited++;
        end
        if (pending.size() != 0) begin
            $display("Timeout: %0d instructions never committed", pending.size());
            errors++;
            pending.delete();
        end
    endtask

    task automatic report_test(input string name, input int errs_start);
        if (errors == errs_start) $display("Test %s: ok", name);
        else $display("Test %s: %0d errors", name, errors - errs_start);
    endtask

    initial begin
        int    errs_start;
        data_t spans [16];
        clk_in        = 1'b0;
        rst_in        = 1'b1;
        rdy_in        = 1'b1;
        clr_in        = 1'b0;
        instr_valid   = 1'b0;
        instr_rd      = '0;
        instr_rs1     = '0;
        instr_rs2     = '0;
        instr_op      = OP_ADD;
        instr_use_imm = 1'b0;
        instr_imm     = '0;
        lfsr          = 32'h8510ecfd;
        model         = '0;
        errors        = 0;
        commits       = 0;
        accepted      = 0;
        dropped       = 0;
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        errs_start = errors;
        for (int i = 1; i <= 6; i++) begin
            send_instr(make_instr(reg_idx_t'(i), '0, '0, op_t'(i % 4), 1'b1,
                                  data_t'(32'h1234_0000 + i * 32'h111)));
        end
        drain();
        report_test("independent", errs_start);

        // Alternate r8 and r9, each reading the other's last writer.
        errs_start = errors;
        for (int i = 0; i < 8; i++) begin
            send_instr(make_instr(reg_idx_t'(8 + i % 2), reg_idx_t'((i == 0) ? 1 : 9 - i % 2),
                                  reg_idx_t'(8 + i % 2), op_t'(i % 4), i % 3 == 0,
                                  data_t'(32'h0f0f_0011 * (i + 1))));
        end
        drain();
        report_test("dependency chains", errs_start);

        errs_start = errors;
        send_instr(make_instr('0, '0, '0, OP_ADD, 1'b1, 32'hdead_beef));
        drain();  // Readers below see r0 after its write has committed.
        send_instr(make_instr(reg_idx_t'(10), '0, '0, OP_ADD, 1'b0, 32'h0));
        send_instr(make_instr(reg_idx_t'(11), '0, '0, OP_XOR, 1'b1, 32'h5));
        drain();
        report_test("register 0", errs_start);

        errs_start = errors;
        send_random(200);
        drain();
        report_test("random stream", errs_start);

        errs_start = errors;
        for (int k = 0; k < 16; k++) begin
            spans[k] = take_bits(3) + 1;
        end
        fork
            send_random(40);
            begin
                for (int k = 0; k < 16; k += 2) begin
                    repeat (spans[k]) @(negedge clk_in);
                    rdy_in = 1'b0;
                    repeat (spans[k + 1]) @(negedge clk_in);
                    rdy_in = 1'b1;
                end
            end
        join
        drain();
        report_test("freeze", errs_start);

        errs_start = errors;
        for (int i = 0; i < 5; i++) begin
            send_instr(make_instr(reg_idx_t'(16 + i), '0, '0, OP_ADD, 1'b1,
                                  data_t'(32'h100 + i)));
        end
        clr_in = 1'b1;
        @(negedge clk_in);
        clr_in = 1'b0;
        if (dropped == 0) begin
            $display("Flush in mid-stream dropped no instructions");
            errors++;
        end
        repeat (6) @(negedge clk_in);
        for (int i = 0; i < 5; i++) begin
            send_instr(make_instr(reg_idx_t'(21 + i), reg_idx_t'(16 + i), '0, OP_ADD, 1'b1,
                                  32'h1));
        end
        drain();
        report_test("flush", errs_start);

        $display("Done: %0d accepted, %0d commits checked, %0d errors",
                 accepted, commits, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
